/* Makefile */
# Verilator build and run of the dense layer testbench

VERILATOR ?= verilator
TOP       ?= dense_layer_tb
FILELIST  ?= dense_layer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* bench/dense_layer_sva.sv */
`timescale 1ns/1ps

module dense_layer_sva (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      req,
  input logic                      ack,
  input dense_types_pkg::res_vec_t dout
);

  // count of failed assertions
  int err_cnt = 0;

  // ack is cleared by the async reset
  a_ack_rst: assert property (@(posedge clk) !rst_n |=> !ack)
    else begin
      err_cnt = err_cnt + 1;
      $error("ack high while reset is asserted");
    end

  // ack only answers a pending request
  a_ack_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
    else begin
      err_cnt = err_cnt + 1;
      $error("ack rose without a request");
    end

  // result held for the whole ack phase
  a_dout_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ack && $past(ack) |-> $stable(dout))
    else begin
      err_cnt = err_cnt + 1;
      $error("dout changed while ack was high");
    end

  // four-phase release
  a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(req) |=> !ack)
    else begin
      err_cnt = err_cnt + 1;
      $error("ack still high two cycles after req fell");
    end

endmodule

bind dense_layer dense_layer_sva u_sva (
  .clk   (clk),
  .rst_n (rst_n),
  .req   (req),
  .ack   (ack),
  .dout  (dout)
);

/* bench/dense_layer_tb.sv */
`timescale 1ns/1ps

module dense_layer_tb;
  import dense_cfg_pkg::*;
  import dense_types_pkg::*;

  localparam int TIMEOUT = 50;
  localparam int W_MAX   = 2**(W_W-1) - 1;
  localparam int W_MIN   = -(2**(W_W-1));

  logic      clk;
  logic      rst_n;
  logic      req;
  op_t       op;
  row_addr_t row;
  w_row_t    din;
  logic      ack;
  res_vec_t  dout;
  res_vec_t  res;
  w_row_t    d;

  // reference model of weights, gradients and saved x
  int w_m   [OUT_DIM][IN_DIM];
  int g_m   [OUT_DIM][IN_DIM];
  int x_m   [IN_DIM];
  int exp_v [IN_DIM];

  dense_layer dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .op    (op),
    .row   (row),
    .din   (din),
    .ack   (ack),
    .dout  (dout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers

  function automatic int elem(input w_row_t r, input int i);
    wt_t e;
    e = r[i*W_W +: W_W];
    return int'(e);
  endfunction

  // magnitudes of 64 and up, enough to saturate the update
  function automatic w_row_t big_row();
    w_row_t r;
    int     v;
    for (int i = 0; i < IN_DIM; i++) begin
      v = 64 + int'($urandom % 64);
      if ($urandom % 2 == 1) begin
        v = -v;
      end
      r[i*W_W +: W_W] = wt_t'(v);
    end
    return r;
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input int exp, input int got);
    assert (got == exp) else begin
      $display("Error %s: expected %0d, actual %0d", name, exp, got);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_res(input string name);
    for (int i = 0; i < IN_DIM; i++) begin
      check_val($sformatf("%s dout[%0d]", name, i), exp_v[i],
                int'(acc_t'(res[i*ACC_W +: ACC_W])));
    end
  endtask

  // a failed handshake assertion ends the run at once
  always @(posedge clk) begin
    if (dut0.u_sva.err_cnt != 0) begin
      fail_stop("a handshake assertion failed");
    end
  end

  // one four-phase transfer, host releases req after a random delay
  task automatic do_cmd(input op_t c, input row_addr_t r, input w_row_t dv);
    int n;
    int hold;
    int lat;
    hold = $urandom % 4;
    case (c)
      OP_LOAD: lat = 2;
      OP_ZERO: lat = OUT_DIM + 1;
      default: lat = OUT_DIM + 2;
    endcase
    @(posedge clk);
    req <= 1'b1;
    op  <= c;
    row <= r;
    din <= dv;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (ack !== 1'b1 && n < TIMEOUT);
    if (ack !== 1'b1) begin
      fail_stop("timeout waiting for ack to rise");
    end
    check_val($sformatf("latency op %0d", c), lat, n - 2);
    res = dout;
    repeat (hold) @(posedge clk);
    req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (ack !== 1'b0 && n < TIMEOUT);
    if (ack !== 1'b0) begin
      fail_stop("timeout waiting for ack to fall");
    end
  endtask

  // ----------------------------------------------------------------------
  // reference model

  task automatic model_fwd(input w_row_t xv);
    for (int i = 0; i < IN_DIM; i++) x_m[i] = elem(xv, i);
    for (int j = 0; j < OUT_DIM; j++) begin
      exp_v[j] = 0;
      for (int i = 0; i < IN_DIM; i++) exp_v[j] += w_m[j][i] * x_m[i];
    end
  endtask

  // dx from W transposed, grad wraps at its element width
  task automatic model_bwd(input w_row_t dy);
    for (int i = 0; i < IN_DIM; i++) exp_v[i] = 0;
    for (int j = 0; j < OUT_DIM; j++) begin
      for (int i = 0; i < IN_DIM; i++) begin
        exp_v[i] += w_m[j][i] * elem(dy, j);
        g_m[j][i] = int'(grad_t'(g_m[j][i] + elem(dy, j) * x_m[i]));
      end
    end
  endtask

  task automatic model_upd();
    int v;
    for (int j = 0; j < OUT_DIM; j++) begin
      for (int i = 0; i < IN_DIM; i++) begin
        v = w_m[j][i] - (g_m[j][i] >>> LR_SHIFT);
        w_m[j][i] = (v > W_MAX) ? W_MAX : (v < W_MIN) ? W_MIN : v;
      end
    end
  endtask

  task automatic zero_grads();
    do_cmd(OP_ZERO, '0, '0);
    g_m = '{default: 0};
  endtask

  initial begin
    void'($urandom(32'h97998ff9));
    rst_n = 1'b0;
    req   = 1'b0;
    op    = OP_LOAD;
    row   = '0;
    din   = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_val("reset ack", 0, int'(ack));

    // weights and gradients start unknown
    for (int r = 0; r < OUT_DIM; r++) begin
      d = w_row_t'($urandom);
      do_cmd(OP_LOAD, row_addr_t'(r), d);
      for (int i = 0; i < IN_DIM; i++) w_m[r][i] = elem(d, i);
    end
    zero_grads();

    d = w_row_t'($urandom);
    do_cmd(OP_FWD, '0, d);
    model_fwd(d);
    check_res("forward");

    d = w_row_t'($urandom);
    do_cmd(OP_BWD, '0, d);
    model_bwd(d);
    check_res("backward");

    // two accumulated backward passes, then the sgd step
    zero_grads();
    d = big_row();
    do_cmd(OP_FWD, '0, d);
    model_fwd(d);
    check_res("accumulate forward");
    for (int k = 0; k < 2; k++) begin
      d = big_row();
      do_cmd(OP_BWD, '0, d);
      model_bwd(d);
      check_res($sformatf("accumulate backward %0d", k));
    end
    do_cmd(OP_UPD, '0, '0);
    model_upd();
    d = w_row_t'($urandom);
    do_cmd(OP_FWD, '0, d);
    model_fwd(d);
    check_res("update forward");

    // zero gradients leave W unchanged
    zero_grads();
    do_cmd(OP_UPD, '0, '0);
    model_upd();
    d = w_row_t'($urandom);
    do_cmd(OP_FWD, '0, d);
    model_fwd(d);
    check_res("zero update forward");

    if (dut0.u_sva.err_cnt != 0) begin
      $display("handshake assertions failed %0d times", dut0.u_sva.err_cnt);
      $display("ERRORS FOUND");
      $fatal(1);
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* dense_layer.f */
verilog/dense_cfg_pkg.sv
verilog/dense_types_pkg.sv
verilog/dense_mem_if.sv
verilog/dense_row_ram.sv
verilog/dense_ctrl.sv
verilog/dense_mac.sv
verilog/dense_update.sv
verilog/dense_layer.sv
bench/dense_layer_sva.sv
bench/dense_layer_tb.sv

/* verilog/dense_cfg_pkg.sv */
package dense_cfg_pkg;

  // layer shape, IN_DIM and OUT_DIM are kept equal
  localparam int IN_DIM  = 4;
  localparam int OUT_DIM = 4;
  localparam int ROW_AW  = 2;

  // element widths, all signed
  localparam int W_W   = 8;
  localparam int G_W   = 20;
  localparam int ACC_W = 20;

  // sgd step is grad >>> LR_SHIFT
  localparam int LR_SHIFT = 4;

  // command codes
  localparam int OP_W = 3;
  localparam logic [OP_W-1:0] OP_LOAD = 3'd0;
  localparam logic [OP_W-1:0] OP_ZERO = 3'd1;
  localparam logic [OP_W-1:0] OP_FWD  = 3'd2;
  localparam logic [OP_W-1:0] OP_BWD  = 3'd3;
  localparam logic [OP_W-1:0] OP_UPD  = 3'd4;

endpackage

/* verilog/dense_ctrl.sv */
`timescale 1ns/1ps

module dense_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req,
  input  dense_types_pkg::op_t       op,
  input  dense_types_pkg::row_addr_t row,
  output logic                       ack,
  output logic                       cap_x,
  output logic                       clr_acc,
  output logic                       fwd_acc,
  output logic                       bwd_acc,
  output dense_types_pkg::op_t       cur_op,
  output dense_types_pkg::row_addr_t wr_row,
  dense_mem_if.ctrl                  wmem,
  dense_mem_if.ctrl                  gmem
);
  import dense_cfg_pkg::*;
  import dense_types_pkg::*;

  ctrl_state_t state;
  row_addr_t   cnt;
  row_addr_t   rd_addr;
  logic        issue;
  logic        vld;
  logic        rd_op;

  // ---------------------------------------------------------------------
  // address issue and strobes

  assign issue   = (state == LOAD) || (state == ZERO) || (state == FWD) ||
                   (state == BWD) || (state == UPD);
  assign rd_addr = (state == LOAD) ? row : cnt;
  // commands that need a drain cycle after the last row
  assign rd_op   = (cur_op == OP_FWD) || (cur_op == OP_BWD) || (cur_op == OP_UPD);

  assign wmem.addr = rd_addr;
  assign gmem.addr = rd_addr;
  assign wmem.we   = vld && ((cur_op == OP_LOAD) || (cur_op == OP_UPD));
  assign gmem.we   = vld && ((cur_op == OP_ZERO) || (cur_op == OP_BWD));

  assign clr_acc = (state == IDLE) && req;
  assign cap_x   = (state == IDLE) && req && (op == OP_FWD);
  assign fwd_acc = vld && (cur_op == OP_FWD);
  assign bwd_acc = vld && (cur_op == OP_BWD);

  // ---------------------------------------------------------------------
  // state machine and four-phase ack

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      cnt    <= '0;
      cur_op <= OP_LOAD;
      ack    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          cnt <= '0;
          if (req) begin
            cur_op <= op;
            case (op)
              OP_LOAD: state <= LOAD;
              OP_ZERO: state <= ZERO;
              OP_FWD:  state <= FWD;
              OP_BWD:  state <= BWD;
              OP_UPD:  state <= UPD;
              default: state <= DONE;
            endcase
          end
        end
        LOAD: state <= DONE;
        ZERO, FWD, BWD, UPD: begin
          cnt <= cnt + 1'b1;
          if (cnt == row_addr_t'(OUT_DIM - 1)) begin
            state <= DONE;
          end
        end
        DONE: begin
          if (ack && !req) begin
            ack   <= 1'b0;
            state <= IDLE;
          end else if (!ack && req && (!rd_op || !vld)) begin
            ack <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // delayed row for read-modify-write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld    <= 1'b0;
      wr_row <= '0;
    end else begin
      vld    <= issue;
      wr_row <= rd_addr;
    end
  end

endmodule

/* verilog/dense_layer.sv */
`timescale 1ns/1ps

module dense_layer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req,
  input  dense_types_pkg::op_t       op,
  input  dense_types_pkg::row_addr_t row,
  input  dense_types_pkg::w_row_t    din,
  output logic                       ack,
  output dense_types_pkg::res_vec_t  dout
);
  import dense_cfg_pkg::*;
  import dense_types_pkg::*;

  logic      cap_x;
  logic      clr_acc;
  logic      fwd_acc;
  logic      bwd_acc;
  op_t       cur_op;
  row_addr_t wr_row;
  w_row_t    x_saved;

  // ---------------------------------------------------------------------
  // weight and gradient row memories

  dense_mem_if #(.DATA_W($bits(w_row_t))) wmem ();
  dense_mem_if #(.DATA_W($bits(g_row_t))) gmem ();

  dense_row_ram #(
    .DATA_W ($bits(w_row_t)),
    .DEPTH  (OUT_DIM)
  ) u_wram (
    .clk (clk),
    .mem (wmem)
  );

  dense_row_ram #(
    .DATA_W ($bits(g_row_t)),
    .DEPTH  (OUT_DIM)
  ) u_gram (
    .clk (clk),
    .mem (gmem)
  );

  // ---------------------------------------------------------------------
  // control and datapaths

  dense_ctrl u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .op      (op),
    .row     (row),
    .ack     (ack),
    .cap_x   (cap_x),
    .clr_acc (clr_acc),
    .fwd_acc (fwd_acc),
    .bwd_acc (bwd_acc),
    .cur_op  (cur_op),
    .wr_row  (wr_row),
    .wmem    (wmem),
    .gmem    (gmem)
  );

  dense_mac u_mac (
    .clk     (clk),
    .rst_n   (rst_n),
    .din     (din),
    .cap_x   (cap_x),
    .clr_acc (clr_acc),
    .fwd_acc (fwd_acc),
    .bwd_acc (bwd_acc),
    .rd_row  (wr_row),
    .wmem    (wmem),
    .x_saved (x_saved),
    .dout    (dout)
  );

  dense_update u_update (
    .cur_op  (cur_op),
    .din     (din),
    .x_saved (x_saved),
    .wr_row  (wr_row),
    .wmem    (wmem),
    .gmem    (gmem)
  );

endmodule

/* verilog/dense_mac.sv */
`timescale 1ns/1ps

module dense_mac (
  input  logic                       clk,
  input  logic                       rst_n,
  input  dense_types_pkg::w_row_t    din,
  input  logic                       cap_x,
  input  logic                       clr_acc,
  input  logic                       fwd_acc,
  input  logic                       bwd_acc,
  input  dense_types_pkg::row_addr_t rd_row,
  dense_mem_if.rd                    wmem,
  output dense_types_pkg::w_row_t    x_saved,
  output dense_types_pkg::res_vec_t  dout
);
  import dense_cfg_pkg::*;
  import dense_types_pkg::*;

  acc_t                    acc [IN_DIM];
  acc_t                    dot;
  wt_t                     dy;
  wt_t                     w_el   [IN_DIM];
  wt_t                     x_el   [IN_DIM];
  logic signed [2*W_W-1:0] f_prod [IN_DIM];
  logic signed [2*W_W-1:0] b_prod [IN_DIM];

  // products for both directions from the current weight row
  always_comb begin
    dy  = din[rd_row*W_W +: W_W];
    dot = '0;
    for (int i = 0; i < IN_DIM; i++) begin
      w_el[i]   = wmem.rdata[i*W_W +: W_W];
      x_el[i]   = x_saved[i*W_W +: W_W];
      f_prod[i] = w_el[i] * x_el[i];
      b_prod[i] = w_el[i] * dy;
      dot       = dot + f_prod[i];
    end
  end

  // x kept for backward and later commands
  always_ff @(posedge clk) begin
    if (cap_x) begin
      x_saved <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < IN_DIM; i++) acc[i] <= '0;
    end else if (clr_acc) begin
      for (int i = 0; i < IN_DIM; i++) acc[i] <= '0;
    end else if (fwd_acc) begin
      acc[rd_row] <= dot;
    end else if (bwd_acc) begin
      // dx[i] += W[j][i] * dy[j]
      for (int i = 0; i < IN_DIM; i++) acc[i] <= acc[i] + b_prod[i];
    end
  end

  always_comb begin
    for (int i = 0; i < IN_DIM; i++) dout[i*ACC_W +: ACC_W] = acc[i];
  end

endmodule

/* verilog/dense_mem_if.sv */
`timescale 1ns/1ps

interface dense_mem_if #(
  parameter int DATA_W = 32
);
  import dense_types_pkg::*;

  row_addr_t         addr;
  logic              we;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;

  // controller owns address and write strobe
  modport ctrl (output addr, output we);
  // datapath builds the write word from the row just read
  modport data (output wdata, input rdata);
  modport mem  (input addr, input we, input wdata, output rdata);
  // read-only tap
  modport rd   (input rdata);

endinterface

/* verilog/dense_row_ram.sv */
`timescale 1ns/1ps

module dense_row_ram #(
  parameter int DATA_W = 32,
  parameter int DEPTH  = 4
) (
  input logic      clk,
  dense_mem_if.mem mem
);
  import dense_types_pkg::*;

  logic [DATA_W-1:0] ram [DEPTH];
  // row read last cycle, also the write-back target
  row_addr_t         addr_q;

  // registered read, write lands on the previous address
  always_ff @(posedge clk) begin
    addr_q    <= mem.addr;
    mem.rdata <= ram[mem.addr];
    if (mem.we) begin
      ram[addr_q] <= mem.wdata;
    end
  end

endmodule

/* verilog/dense_types_pkg.sv */
package dense_types_pkg;

  import dense_cfg_pkg::*;

  // scalar elements
  typedef logic signed [W_W-1:0]   wt_t;
  typedef logic signed [G_W-1:0]   grad_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // row index and command
  typedef logic [ROW_AW-1:0] row_addr_t;
  typedef logic [OP_W-1:0]   op_t;

  // packed rows, element i sits at bits [i*width +: width]
  typedef logic [IN_DIM*W_W-1:0]   w_row_t;
  typedef logic [IN_DIM*G_W-1:0]   g_row_t;
  typedef logic [IN_DIM*ACC_W-1:0] res_vec_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE, LOAD, ZERO, FWD, BWD, UPD, DONE
  } ctrl_state_t;

endpackage

/* verilog/dense_update.sv */
`timescale 1ns/1ps

module dense_update (
  input  dense_types_pkg::op_t       cur_op,
  input  dense_types_pkg::w_row_t    din,
  input  dense_types_pkg::w_row_t    x_saved,
  input  dense_types_pkg::row_addr_t wr_row,
  dense_mem_if.data                  wmem,
  dense_mem_if.data                  gmem
);
  import dense_cfg_pkg::*;
  import dense_types_pkg::*;

  wt_t                     dy;
  wt_t                     w_el;
  wt_t                     x_el;
  grad_t                   g_el;
  grad_t                   step;
  logic signed [2*W_W-1:0] prod;
  logic signed [G_W:0]     diff;
  w_row_t                  w_upd;
  g_row_t                  g_acc;

  // clamp to the signed weight range
  function automatic wt_t sat_w(input logic signed [G_W:0] v);
    if (v > (2**(W_W-1) - 1)) begin
      return wt_t'(2**(W_W-1) - 1);
    end else if (v < -(2**(W_W-1))) begin
      return wt_t'(-(2**(W_W-1)));
    end
    return v[W_W-1:0];
  endfunction

  always_comb begin
    dy    = din[wr_row*W_W +: W_W];
    w_upd = '0;
    g_acc = '0;
    for (int i = 0; i < IN_DIM; i++) begin
      w_el = wmem.rdata[i*W_W +: W_W];
      x_el = x_saved[i*W_W +: W_W];
      g_el = gmem.rdata[i*G_W +: G_W];
      // grad[j][i] += dy[j] * x[i]
      prod                = dy * x_el;
      g_acc[i*G_W +: G_W] = g_el + prod;
      // sgd step with shift learning rate
      step                = g_el >>> LR_SHIFT;
      diff                = w_el - step;
      w_upd[i*W_W +: W_W] = sat_w(diff);
    end
  end

  // load passes din, zero clears the row
  always_comb begin
    wmem.wdata = (cur_op == OP_UPD) ? w_upd : din;
    gmem.wdata = (cur_op == OP_BWD) ? g_acc : '0;
  end

endmodule
